// File: verilog/fpga_pkg.sv
package fpga_pkg;

  // LUT inputs per slice, also slices per tile
  localparam int lut_k = 4;

  // Truth table entries for one LUT
  localparam int tt_w = 1 << lut_k;

  // Width of a slice index inside a tile
  localparam int sel_w = $clog2(lut_k);

  // Truth table plus two mode bits
  localparam int slice_cfg_w = tt_w + 2;

  // Whole tile configuration, one field per slice
  localparam int tile_cfg_w = lut_k * slice_cfg_w;

  // Mode field position inside a slice field
  localparam int mode_lsb = tt_w;

  // Slice operation
  // Bit 0 of the mode selects the output flop
  // Bit 1 of the mode enables the carry logic
  typedef enum logic [1:0] {
    // LUT value straight out
    mode_comb      = 2'b00,
    // LUT value through the flop
    mode_reg       = 2'b01,
    // LUT value XOR carry in, unregistered
    mode_carry     = 2'b10,
    // Sum through the flop
    mode_carry_reg = 2'b11
  } slice_mode_e;

endpackage

// File: verilog/config_chain.sv
module config_chain (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            cen,
  input  logic                            cset,
  input  logic                            shift_in,
  output logic                            shift_out,
  output logic [fpga_pkg::tile_cfg_w-1:0] active_cfg
);

  // Shadow chain, filled serially while the fabric keeps running
  logic [fpga_pkg::tile_cfg_w-1:0] shadow;

  // Active bits seen by the slices
  logic [fpga_pkg::tile_cfg_w-1:0] active_q;

  // New bit enters at index 0
  // Everything moves up one place per enabled clock
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shadow <= '0;
    end else if (cen) begin
      shadow <= {shadow[fpga_pkg::tile_cfg_w-2:0], shift_in};
    end
  end

  // Whole shadow copied at once on cset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active_q <= '0;
    end else if (cset) begin
      active_q <= shadow;
    end
  end

  // Top bit continues into the tile above
  assign shift_out = shadow[fpga_pkg::tile_cfg_w-1];

  assign active_cfg = active_q;

  // Latching while shifting would capture a half-loaded stream
  property p_no_latch_during_shift;
    @(posedge clk) disable iff (!rst_n)
      cset |-> !cen;
  endproperty

  a_no_latch_during_shift: assert property (p_no_latch_during_shift)
    else $error("cset raised while cen is still high");

endmodule

// File: verilog/lut_slice.sv
module lut_slice (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             en,
  input  logic [fpga_pkg::slice_cfg_w-1:0] cfg,
  input  logic [fpga_pkg::lut_k-1:0]       lut_in,
  input  logic [fpga_pkg::sel_w-1:0]       gen_sel,
  input  logic                             carry_in,
  output logic                             carry_out,
  output logic                             q
);

  // Decoded configuration
  logic [fpga_pkg::tt_w-1:0] truth_tab;
  fpga_pkg::slice_mode_e     mode;

  // Mode flags
  logic use_carry;
  logic use_reg;

  // LUT value and the pre-flop result
  logic lut_val;
  logic comb_val;

  // Output flop
  logic q_reg;

  assign truth_tab = cfg[fpga_pkg::tt_w-1:0];
  assign mode      = fpga_pkg::slice_mode_e'(cfg[fpga_pkg::mode_lsb +: 2]);

  always_comb begin
    case (mode)
      fpga_pkg::mode_comb: begin
        use_carry = 1'b0;
        use_reg   = 1'b0;
      end
      fpga_pkg::mode_reg: begin
        use_carry = 1'b0;
        use_reg   = 1'b1;
      end
      fpga_pkg::mode_carry: begin
        use_carry = 1'b1;
        use_reg   = 1'b0;
      end
      default: begin
        use_carry = 1'b1;
        use_reg   = 1'b1;
      end
    endcase
  end

  // Whole west bus indexes the table
  assign lut_val = truth_tab[lut_in];

  // Sum bit when carry logic is on
  assign comb_val = use_carry ? (lut_val ^ carry_in) : lut_val;

  // LUT value 1 propagates, 0 generates from own west bit
  // Without carry mode the chain just passes through
  assign carry_out = !use_carry ? carry_in :
                     lut_val    ? carry_in : lut_in[gen_sel];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      q_reg <= 1'b0;
    end else if (en) begin
      q_reg <= comb_val;
    end
  end

  assign q = use_reg ? q_reg : comb_val;

  // Output settles to a known value one cycle out of reset
  property p_q_known;
    @(posedge clk) disable iff (!rst_n)
      $past(rst_n) |-> !$isunknown(q);
  endproperty

  a_q_known: assert property (p_q_known)
    else $error("slice output unknown after reset");

endmodule

// File: verilog/clb_tile.sv
module clb_tile (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       en,
  input  logic                       cen,
  input  logic                       cset,
  input  logic                       shift_in,
  output logic                       shift_out,
  input  logic [fpga_pkg::lut_k-1:0] west_in,
  output logic [fpga_pkg::lut_k-1:0] east_out,
  input  logic                       carry_in,
  output logic                       carry_out
);

  // Active configuration of the whole tile
  logic [fpga_pkg::tile_cfg_w-1:0] active_cfg;

  // Carry ripple, entry 0 from below, last entry leaves upward
  logic [fpga_pkg::lut_k:0] carry_link;

  // Tile's slice of the column chain
  config_chain u_cfg (
    .clk        (clk),
    .rst_n      (rst_n),
    .cen        (cen),
    .cset       (cset),
    .shift_in   (shift_in),
    .shift_out  (shift_out),
    .active_cfg (active_cfg)
  );

  assign carry_link[0] = carry_in;

  genvar s;
  generate
    for (s = 0; s < fpga_pkg::lut_k; s = s + 1) begin : g_slice
      // Slice s picks its own west bit as generate input
      localparam logic [fpga_pkg::sel_w-1:0] gen_idx = s;

      // Field s of the tile configuration
      logic [fpga_pkg::slice_cfg_w-1:0] slice_cfg;

      assign slice_cfg = active_cfg[s*fpga_pkg::slice_cfg_w +: fpga_pkg::slice_cfg_w];

      lut_slice u_slice (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .cfg       (slice_cfg),
        .lut_in    (west_in),
        .gen_sel   (gen_idx),
        .carry_in  (carry_link[s]),
        .carry_out (carry_link[s+1]),
        .q         (east_out[s])
      );
    end
  endgenerate

  // Slice 3 carry continues into the tile above
  assign carry_out = carry_link[fpga_pkg::lut_k];

endmodule

// File: verilog/fpga.sv
module fpga #(
  parameter int MX = 3,
  parameter int MY = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          en,
  // Per-column shift enable
  input  logic [MX-1:0]                 cen,
  // Per-column configuration latch
  input  logic [MX-1:0]                 cset,
  input  logic [MX-1:0]                 shift_in,
  // West edge, one nibble per row
  input  logic [MY*fpga_pkg::lut_k-1:0] data_in,
  input  logic [MX-1:0]                 carry_in_col,
  // East edge, one nibble per row
  output logic [MY*fpga_pkg::lut_k-1:0] data_out,
  output logic [MX-1:0]                 carry_out_col
);

  // Tile outputs, indexed [x][y]
  logic                       shift_up [MX][MY];
  logic                       carry_up [MX][MY];
  logic [fpga_pkg::lut_k-1:0] east_bus [MX][MY];

  genvar x;
  genvar y;
  generate
    for (x = 0; x < MX; x = x + 1) begin : g_col
      for (y = 0; y < MY; y = y + 1) begin : g_row
        // Tile inputs from the neighbors
        logic                       tile_shift;
        logic                       tile_carry;
        logic [fpga_pkg::lut_k-1:0] tile_west;

        // Bottom tile takes the column pins
        if (y == 0) begin : g_bottom
          assign tile_shift = shift_in[x];
          assign tile_carry = carry_in_col[x];
        end else begin : g_stack
          assign tile_shift = shift_up[x][y-1];
          assign tile_carry = carry_up[x][y-1];
        end

        // West column reads the edge pins
        if (x == 0) begin : g_west_edge
          assign tile_west = data_in[y*fpga_pkg::lut_k +: fpga_pkg::lut_k];
        end else begin : g_west_tile
          assign tile_west = east_bus[x-1][y];
        end

        clb_tile u_clb (
          .clk       (clk),
          .rst_n     (rst_n),
          .en        (en),
          .cen       (cen[x]),
          .cset      (cset[x]),
          .shift_in  (tile_shift),
          .shift_out (shift_up[x][y]),
          .west_in   (tile_west),
          .east_out  (east_bus[x][y]),
          .carry_in  (tile_carry),
          .carry_out (carry_up[x][y])
        );
      end

      // Top of each carry chain
      assign carry_out_col[x] = carry_up[x][MY-1];
    end

    // East edge from the last column
    for (y = 0; y < MY; y = y + 1) begin : g_east
      assign data_out[y*fpga_pkg::lut_k +: fpga_pkg::lut_k] = east_bus[MX-1][y];
    end
  endgenerate

endmodule

// File: tb/fpga_tb.sv
module fpga_tb;

  // Two columns by three rows
  localparam int MX = 2;
  localparam int MY = 3;
  localparam int dw = MY * fpga_pkg::lut_k;
  localparam int bw = MY * fpga_pkg::tile_cfg_w;
  localparam string input_path = "tb/fpga_input.txt";

  logic          clk;
  logic          rst_n;
  logic          en;
  logic [MX-1:0] cen;
  logic [MX-1:0] cset;
  logic [MX-1:0] shift_in;
  logic [dw-1:0] data_in;
  logic [MX-1:0] carry_in_col;
  logic [dw-1:0] data_out;
  logic [MX-1:0] carry_out_col;

  // Random data source and run bookkeeping
  integer seed = 48;
  int     record_count = 0;
  int     checks_done = 0;
  logic   count_ready = 1'b0;

  fpga #(
    .MX (MX),
    .MY (MY)
  ) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .cen           (cen),
    .cset          (cset),
    .shift_in      (shift_in),
    .data_in       (data_in),
    .carry_in_col  (carry_in_col),
    .data_out      (data_out),
    .carry_out_col (carry_out_col)
  );

  always #5 clk = ~clk;

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    checks_done++;
    if (actual !== expected) begin
      $display("mismatch %s: got 0x%h expected 0x%h", name, actual, expected);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Something failed");
    $fatal(1);
  endtask

  // Records are lines that open with a capital letter
  task automatic count_records(output int n);
    int         fd;
    int         c;
    logic [7:0] ch;
    logic       line_start;
    n = 0;
    line_start = 1'b1;
    fd = $fopen(input_path, "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      ch = c[7:0];
      if (line_start && ch >= "A" && ch <= "Z") begin
        n++;
      end
      line_start = (ch == "\n");
      c = $fgetc(fd);
    end
    $fclose(fd);
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != -1 && c != 10) begin
      c = $fgetc(fd);
    end
  endtask

  // MSB first so the first bit ends up at the top of the column
  task automatic load_column(input int col, input logic [bw-1:0] bits);
    for (int i = bw - 1; i >= 0; i--) begin
      shift_in[col] = bits[i];
      cen[col] = 1'b1;
      @(negedge clk);
    end
    cen = '0;
    shift_in = '0;
  endtask

  task automatic latch_columns(input logic [MX-1:0] mask);
    cset = mask;
    @(negedge clk);
    cset = '0;
  endtask

  // Drive now and compare one clock later on the falling edge
  task automatic apply_vector(input logic v_en, input logic [dw-1:0] din,
                              input logic [MX-1:0] cin, input logic [dw-1:0] dout,
                              input logic [MX-1:0] cout);
    en = v_en;
    data_in = din;
    carry_in_col = cin;
    @(negedge clk);
    check_val("data_out", 32'(data_out), 32'(dout));
    check_val("carry_out_col", 32'(carry_out_col), 32'(cout));
  endtask

  // Outputs expected constant whatever data_in holds
  task automatic apply_random(input int n, input logic v_en, input logic [MX-1:0] cin,
                              input logic [dw-1:0] dout, input logic [MX-1:0] cout);
    integer rnd;
    for (int k = 0; k < n; k++) begin
      rnd = $random(seed);
      apply_vector(v_en, rnd[dw-1:0], cin, dout, cout);
    end
  endtask

  task automatic need_fields(input int got, input int want, input logic [7:0] kind);
    if (got != want) begin
      abort_run($sformatf("malformed %c record in the stimulus file", kind));
    end
  endtask

  initial begin : main
    int            fd;
    int            code;
    int            col;
    int            n;
    logic          done;
    logic [7:0]    kind;
    logic [bw-1:0] bits;
    logic          v_en;
    logic [dw-1:0] v_din;
    logic [dw-1:0] v_dout;
    logic [MX-1:0] v_cin;
    logic [MX-1:0] v_cout;
    clk = 1'b0;
    rst_n = 1'b0;
    en = 1'b1;
    cen = '0;
    cset = '0;
    shift_in = '0;
    data_in = '0;
    carry_in_col = '0;
    count_records(record_count);
    count_ready = 1'b1;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    fd = $fopen(input_path, "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file");
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) begin
        abort_run("stimulus file ended before the end marker");
      end
      case (kind)
        "#": skip_line(fd);
        "L": begin
          code = $fscanf(fd, "%d %h", col, bits);
          need_fields(code, 2, kind);
          load_column(col, bits);
        end
        "S": begin
          code = $fscanf(fd, "%h", v_cin);
          need_fields(code, 1, kind);
          latch_columns(v_cin);
        end
        "V": begin
          code = $fscanf(fd, "%h %h %h %h %h", v_en, v_din, v_cin, v_dout, v_cout);
          need_fields(code, 5, kind);
          apply_vector(v_en, v_din, v_cin, v_dout, v_cout);
        end
        "R": begin
          code = $fscanf(fd, "%d %h %h %h %h", n, v_en, v_cin, v_dout, v_cout);
          need_fields(code, 5, kind);
          apply_random(n, v_en, v_cin, v_dout, v_cout);
        end
        "W": begin
          code = $fscanf(fd, "%d", n);
          need_fields(code, 1, kind);
          repeat (n) @(negedge clk);
        end
        "E": done = 1'b1;
        default: abort_run($sformatf("unknown record type %c in the stimulus file", kind));
      endcase
    end
    $fclose(fd);
    if (checks_done > 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      abort_run("no output was compared in the whole run");
    end
  end

  // Budget of 250 clocks per record
  // Longest record is a 216-clock bitstream load
  initial begin : watchdog
    wait (count_ready);
    #(record_count * 250 * 10);
    $display("timeout, the run took longer than its records allow");
    $display("Something failed");
    $fatal(1);
  end

endmodule

// File: tb/fpga_input.txt
# L col bitstream_hex | S col_mask | W idle_clocks | E end of file
# V en data_in carry_in_col data_out carry_out_col | R count en carry_in_col data_out carry_out_col
# Nothing latched yet, every output low
R 4 1 0 000 0
V 1 5A3 3 000 3
# Shadows loaded, still nothing latched
L 0 3FC00F0F033330AAAA3FC00F0F033330AAAA3FC00F0F033330AAAA
L 1 003FC0F0F0CCCC5555003FC0F0F0CCCC5555003FC0F0F0CCCC5555
R 3 1 0 000 0
# Identity then inverse
S 3
V 1 000 0 FFF 0
V 1 5A3 0 A5C 0
V 1 FFF 2 000 2
V 1 123 1 EDC 1
# Parity in column 0
L 0 1A65869961A65869961A65869961A65869961A65869961A6586996
S 1
V 1 000 0 FFF 0
V 1 731 0 0F0 0
V 1 F86 0 F0F 0
# Column 0 registered identity, en low holds
L 0 7FC01F0F073331AAAA7FC01F0F073331AAAA7FC01F0F073331AAAA
S 1
V 1 3C5 0 C3A 0
V 1 0F1 0 F0E 0
V 0 AAA 0 F0E 0
V 0 555 0 F0E 0
V 1 555 0 AAA 0
# Column 0 carry mode, inverted tables propagate on 0 and generate on 1
L 0 803FE0F0F8CCCE5555803FE0F0F8CCCE5555803FE0F0F8CCCE5555
S 1
V 1 000 1 FFF 1
V 1 000 0 000 0
V 1 000 2 000 2
V 1 010 0 FF0 1
V 1 010 1 FEF 1
V 1 800 0 800 1
V 1 001 0 FFF 1
# Identity shifted into column 1, old function stays until cset
L 1 3FC00F0F033330AAAA3FC00F0F033330AAAA3FC00F0F033330AAAA
W 2
V 1 010 0 FF0 1
S 2
V 1 010 0 00F 1
V 1 000 1 000 1
V 1 000 0 FFF 0
E

// File: fpga.f
verilog/fpga_pkg.sv
verilog/config_chain.sv
verilog/lut_slice.sv
verilog/clb_tile.sv
verilog/fpga.sv
tb/fpga_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f fpga.f --top-module fpga_tb

./obj_dir/Vfpga_tb | tee sim.log

if grep -q "Everything OK" sim.log; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1
